// ==== vlog.f ====
+incdir+tests
hdl/muldiv_pkg.sv
hdl/int_multiplier.sv
hdl/int_divider.sv
hdl/muldiv_sequencer.sv
hdl/muldiv_unit.sv
tests/tb_muldiv_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_muldiv_unit
RTL_TOP ?= muldiv_unit
FILE_LIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation of $(RTL_TOP) failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/muldiv_model.svh ====
`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

// Expected result of one M-extension operation, straight from the ISA rules
function automatic logic [xlen-1:0] expected_result(input muldiv_op_t op,
		input logic [xlen-1:0] a, input logic [xlen-1:0] b);
	logic signed [2*xlen-1:0]	sa;
	logic signed [2*xlen-1:0]	sb;
	logic signed [2*xlen-1:0]	za;
	logic signed [2*xlen-1:0]	zb;
	logic signed [2*xlen-1:0]	prod;
	logic signed [2*xlen-1:0]	quot;
	logic signed [2*xlen-1:0]	rem;
	logic [xlen-1:0]			res;

	sa			= {{xlen{a[xlen-1]}}, a};
	sb			= {{xlen{b[xlen-1]}}, b};
	za			= {{xlen{1'b0}}, a};
	zb			= {{xlen{1'b0}}, b};

	case (op)
		op_mulhsu:	prod = sa * zb;
		op_mulhu:	prod = za * zb;
		default:	prod = sa * sb;
	endcase

	// Division by zero gives all ones and leaves the dividend as remainder
	if (b == '0) begin
		quot	= '1;
		rem		= za;
	end else if (op == op_divu || op == op_remu) begin
		quot	= za / zb;
		rem		= za % zb;
	end else begin
		// Double width keeps the most negative value over minus one exact
		// Remainder keeps the sign of the dividend
		quot	= sa / sb;
		rem		= sa % sb;
	end

	case (op)
		op_mul:		res = prod[xlen-1:0];
		op_mulh,
		op_mulhsu,
		op_mulhu:	res = prod[2*xlen-1:xlen];
		op_div,
		op_divu:	res = quot[xlen-1:0];
		default:	res = rem[xlen-1:0];
	endcase
	return res;
endfunction

`endif

// ==== tests/tb_muldiv_unit.sv ====
module tb_muldiv_unit;

	import muldiv_pkg::*;

	`include "muldiv_model.svh"

	localparam int drive_delay = 2;
	localparam int reset_cycles = 8;
	localparam int corner_count = 5;
	localparam int random_pairs = 50;
	localparam int max_stall = 6;
	localparam int request_count = 2 * 4 * (corner_count * corner_count + random_pairs) + 40;
	localparam int cycle_limit = request_count * (4 + 2 + max_stall) + reset_cycles + 200;

	localparam logic [xlen-1:0] corners [corner_count] = '{
		32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff
	};

	logic				clk;
	logic				reset;
	logic				req_valid;
	logic				req_ready;
	muldiv_op_t			req_op;
	logic	[xlen-1:0]	req_a;
	logic	[xlen-1:0]	req_b;
	logic				resp_valid;
	logic				resp_ready;
	logic	[xlen-1:0]	resp_data;

	int		seed = 32'hebdab8f3;
	int		pass_count = 0;
	int		fail_count = 0;
	int		cycle_count = 0;

	muldiv_unit u_muldiv_unit (
		.clk		(clk),
		.reset		(reset),
		.req_valid	(req_valid),
		.req_ready	(req_ready),
		.req_op		(req_op),
		.req_a		(req_a),
		.req_b		(req_b),
		.resp_valid	(resp_valid),
		.resp_ready	(resp_ready),
		.resp_data	(resp_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// Starts at drive time after an edge, returns at drive time after the accepting edge
	task automatic send(input muldiv_op_t op, input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		req_op		= op;
		req_a		= a;
		req_b		= b;
		req_valid	= 1'b1;
		@(negedge clk);
		while (!req_ready)
			@(negedge clk);
		@(posedge clk);
		#drive_delay;
		req_valid	= 1'b0;
	endtask

	task automatic receive(output logic [xlen-1:0] data);
		resp_ready = 1'b1;
		@(negedge clk);
		while (!resp_valid)
			@(negedge clk);
		data = resp_data;
		@(posedge clk);
		#drive_delay;
	endtask

	task automatic compare(input muldiv_op_t op, input logic [xlen-1:0] a,
			input logic [xlen-1:0] b, input logic [xlen-1:0] exp, input logic [xlen-1:0] got);
		assert (got === exp) pass_count++;
		else begin
			fail_count++;
			$display("ERR %0t: %s a=%h b=%h expected %h got %h",
				$time, op.name(), a, b, exp, got);
		end
	endtask

	task automatic run_expect(input muldiv_op_t op, input logic [xlen-1:0] a,
			input logic [xlen-1:0] b, input logic [xlen-1:0] exp);
		logic [xlen-1:0] got;

		send(op, a, b);
		receive(got);
		compare(op, a, b, exp, got);
	endtask

	task automatic run_op(input muldiv_op_t op, input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		run_expect(op, a, b, expected_result(op, a, b));
	endtask

	task automatic report_test(input string name, input int start_fails);
		$display("%s finished with %0d errors", name, fail_count - start_fails);
	endtask

	task automatic test_reset_state();
		int start_fails;

		start_fails = fail_count;
		@(negedge clk);
		assert (req_ready === 1'b1 && resp_valid === 1'b0) pass_count++;
		else begin
			fail_count++;
			$display("ERR %0t: after reset req_ready=%b resp_valid=%b, expected 1 and 0",
				$time, req_ready, resp_valid);
		end
		@(posedge clk);
		#drive_delay;
		// Zero operands look like a cleared saved state
		run_op(op_rem, 32'h0, 32'h0);
		run_op(op_rem, 32'hffff_fff9, 32'h2);
		report_test("reset state", start_fails);
	endtask

	// Covers the multiply group (base 0) or the divide group (base 4)
	task automatic test_group(input string name, input int base);
		int start_fails;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;

		start_fails = fail_count;
		for (int i = 0; i < corner_count; i++)
			for (int j = 0; j < corner_count; j++)
				for (int k = 0; k < 4; k++)
					run_op(muldiv_op_t'(base + k), corners[i], corners[j]);
		for (int n = 0; n < random_pairs; n++) begin
			a = $random(seed);
			b = $random(seed);
			if (base == 4 && b == '0)
				b = 32'h1;
			for (int k = 0; k < 4; k++)
				run_op(muldiv_op_t'(base + k), a, b);
		end
		report_test(name, start_fails);
	endtask

	task automatic test_division_rules();
		int start_fails;

		start_fails = fail_count;
		run_expect(op_div, 32'h1234_5678, 32'h0, 32'hffff_ffff);
		run_expect(op_divu, 32'h8765_4321, 32'h0, 32'hffff_ffff);
		run_expect(op_rem, 32'h8765_4321, 32'h0, 32'h8765_4321);
		run_expect(op_remu, 32'h1234_5678, 32'h0, 32'h1234_5678);
		run_expect(op_div, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
		run_expect(op_rem, 32'h8000_0000, 32'hffff_ffff, 32'h0);
		run_op(op_divu, 32'h8000_0000, 32'hffff_ffff);
		run_op(op_remu, 32'h8000_0000, 32'hffff_ffff);
		report_test("division rules", start_fails);
	endtask

	task automatic test_reuse();
		int start_fails;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;

		start_fails = fail_count;
		a = $random(seed);
		b = $random(seed) | 1;
		run_op(op_div, a, b);
		run_op(op_rem, a, b);
		run_op(op_divu, a, b);
		run_op(op_remu, a, b);
		run_op(op_rem, a, b);
		run_op(op_div, a, b);
		run_op(op_div, 32'hffff_fff9, 32'h2);
		run_op(op_rem, 32'hffff_fff9, 32'h2);
		// Partner operation with a different divisor
		run_op(op_div, a, b);
		run_op(op_rem, a, b ^ 32'h10);
		report_test("reuse path", start_fails);
	endtask

	task automatic test_backpressure();
		int start_fails;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] held;
		logic [xlen-1:0] got;

		start_fails = fail_count;
		a = $random(seed);
		b = $random(seed);
		resp_ready = 1'b0;
		send(op_mulhu, a, b);
		@(negedge clk);
		while (!resp_valid)
			@(negedge clk);
		held = resp_data;
		compare(op_mulhu, a, b, expected_result(op_mulhu, a, b), held);
		@(posedge clk);
		#drive_delay;
		// Second request waits behind the held response
		req_op		= op_divu;
		req_a		= b;
		req_b		= a | 1;
		req_valid	= 1'b1;
		repeat (max_stall) begin
			@(negedge clk);
			assert (resp_valid === 1'b1 && resp_data === held && req_ready === 1'b0) pass_count++;
			else begin
				fail_count++;
				$display("Response not held or request taken under back-pressure at time %0t",
					$time);
			end
			@(posedge clk);
			#drive_delay;
		end
		resp_ready = 1'b1;
		@(posedge clk);
		#drive_delay;
		send(op_divu, b, a | 1);
		receive(got);
		compare(op_divu, b, a | 1, expected_result(op_divu, b, a | 1), got);
		report_test("back-pressure", start_fails);
	endtask

	initial begin
		reset		= 1'b1;
		req_valid	= 1'b0;
		req_op		= op_mul;
		req_a		= '0;
		req_b		= '0;
		resp_ready	= 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#drive_delay;
		reset = 1'b0;

		test_reset_state();
		test_group("multiply", 0);
		test_group("divide and remainder", 4);
		test_division_rules();
		test_reuse();
		test_backpressure();

		$display("Checks passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== hdl/muldiv_unit.sv ====
module muldiv_unit (
	input	logic							clk,
	input	logic							reset,

	input	logic							req_valid,
	output	logic							req_ready,
	input	muldiv_pkg::muldiv_op_t			req_op,
	input	logic	[muldiv_pkg::xlen-1:0]	req_a,
	input	logic	[muldiv_pkg::xlen-1:0]	req_b,

	output	logic							resp_valid,
	input	logic							resp_ready,
	output	logic	[muldiv_pkg::xlen-1:0]	resp_data
);

	import muldiv_pkg::*;

	logic				mul_start;
	logic				div_start;
	logic				mul_done;
	logic				div_done;
	logic	[xlen-1:0]	mul_result;
	logic	[xlen-1:0]	div_result;

	muldiv_sequencer u_sequencer (
		.clk		(clk),
		.reset		(reset),
		.req_valid	(req_valid),
		.req_op		(req_op),
		.req_ready	(req_ready),
		.mul_start	(mul_start),
		.div_start	(div_start),
		.mul_done	(mul_done),
		.div_done	(div_done),
		.mul_result	(mul_result),
		.div_result	(div_result),
		.resp_valid	(resp_valid),
		.resp_ready	(resp_ready),
		.resp_data	(resp_data)
	);

	// Both units see the raw request, only the started one loads it
	int_multiplier u_multiplier (
		.clk	(clk),
		.reset	(reset),
		.start	(mul_start),
		.op		(req_op),
		.a		(req_a),
		.b		(req_b),
		.done	(mul_done),
		.result	(mul_result)
	);

	int_divider u_divider (
		.clk	(clk),
		.reset	(reset),
		.start	(div_start),
		.op		(req_op),
		.a		(req_a),
		.b		(req_b),
		.done	(div_done),
		.result	(div_result)
	);

endmodule

// ==== hdl/muldiv_sequencer.sv ====
module muldiv_sequencer (
	input	logic							clk,
	input	logic							reset,

	input	logic							req_valid,
	input	muldiv_pkg::muldiv_op_t			req_op,
	output	logic							req_ready,

	output	logic							mul_start,
	output	logic							div_start,
	input	logic							mul_done,
	input	logic							div_done,
	input	logic	[muldiv_pkg::xlen-1:0]	mul_result,
	input	logic	[muldiv_pkg::xlen-1:0]	div_result,

	output	logic							resp_valid,
	input	logic							resp_ready,
	output	logic	[muldiv_pkg::xlen-1:0]	resp_data
);

	import muldiv_pkg::*;

	typedef enum logic [1:0] {s_idle, s_busy, s_hold} state_t;

	state_t		state;
	logic		use_div;
	logic		accept;
	logic		unit_done;

	assign req_ready	= (state == s_idle);
	assign accept		= req_valid && req_ready;

	// Unit loads its operands at the accepting edge
	assign div_start	= accept && is_div_op(req_op);
	assign mul_start	= accept && !is_div_op(req_op);

	assign unit_done	= use_div ? div_done : mul_done;
	assign resp_valid	= (state == s_hold);

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state	<= s_idle;
			use_div	<= 1'b0;
		end else begin
			case (state)
				s_idle: begin
					if (accept) begin
						state	<= s_busy;
						use_div	<= is_div_op(req_op);
					end
				end
				s_busy: begin
					if (unit_done)
						state <= s_hold;
				end
				s_hold: begin
					if (resp_ready)
						state <= s_idle;
				end
				default: begin
					state <= s_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == s_busy && unit_done)
			resp_data <= use_div ? div_result : mul_result;
	end

	// Only the unit that was started may finish
	other_unit_quiet: assert property (@(posedge clk) disable iff (reset)
		state == s_busy |-> !(use_div ? mul_done : div_done));

	// Units only finish work this block started
	done_only_busy: assert property (@(posedge clk) disable iff (reset)
		(mul_done || div_done) |-> state == s_busy);

	resp_stable: assert property (@(posedge clk) disable iff (reset)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp_data));

endmodule

// ==== hdl/int_divider.sv ====
module int_divider (
	input	logic							clk,
	input	logic							reset,
	input	logic							start,

	input	muldiv_pkg::muldiv_op_t			op,

	input	logic	[muldiv_pkg::xlen-1:0]	a,
	input	logic	[muldiv_pkg::xlen-1:0]	b,

	output	logic							done,
	output	logic	[muldiv_pkg::xlen-1:0]	result
);

	import muldiv_pkg::*;

	typedef enum logic {s_idle, s_calc} state_t;

	state_t						state;
	logic	[count_bits-1:0]	counter;

	// Last started operation, for quotient/remainder reuse
	muldiv_op_t					reg_op;
	logic						saved_valid;
	logic	[xlen-1:0]			prev_a;
	logic	[xlen-1:0]			prev_b;

	logic	[xlen-1:0]			reg_b;
	logic	[xlen-1:0]			reg_res;
	logic	[xlen:0]			reg_rem;
	logic						q_sgn;
	logic						r_sgn;

	logic						a_neg;
	logic						b_neg;
	logic	[xlen-1:0]			mag_a;
	logic	[xlen-1:0]			mag_b;
	logic						reuse;

	logic	[xlen-1:0]			chain_res;
	logic	[xlen-1:0]			chain_b;
	logic	[xlen:0]			acc [0:step_bits];
	logic	[xlen:0]			diff [1:step_bits];
	logic	[step_bits-1:0]		q;

	if (xlen % step_bits != 0) begin : g_width_check
		$fatal(1, "xlen is not a multiple of step_bits");
	end

	// DIV and REM have funct3[0] clear
	assign a_neg	= !op[0] && a[xlen-1];
	assign b_neg	= !op[0] && b[xlen-1];
	assign mag_a	= a_neg ? -a : a;
	assign mag_b	= b_neg ? -b : b;

	assign reuse = saved_valid && prev_a == a && prev_b == b &&
		((reg_op == op_div  && op == op_rem)  ||
		 (reg_op == op_rem  && op == op_div)  ||
		 (reg_op == op_divu && op == op_remu) ||
		 (reg_op == op_remu && op == op_divu));

	always_comb begin
		case (reg_op)
			op_div:		result = q_sgn ? -reg_res : reg_res;
			op_divu:	result = reg_res;
			op_rem:		result = r_sgn ? -reg_rem[xlen-1:0] : reg_rem[xlen-1:0];
			default:	result = reg_rem[xlen-1:0];
		endcase
	end

	// Restoring chain, one quotient bit per trial subtraction
	always_comb begin
		if (start) begin
			chain_res	= mag_a;
			chain_b		= mag_b;
			acc[0]		= '0;
		end else begin
			chain_res	= reg_res;
			chain_b		= reg_b;
			acc[0]		= reg_rem;
		end

		for (int i = 1; i <= step_bits; i++) begin
			diff[i]			= {acc[i-1][xlen-1:0], chain_res[xlen-i]} - {1'b0, chain_b};
			q[step_bits-i]	= !diff[i][xlen];
			acc[i]			= diff[i][xlen] ? {acc[i-1][xlen-1:0], chain_res[xlen-i]} : diff[i];
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state		<= s_idle;
			counter		<= '0;
			done		<= 1'b0;
			reg_op		<= op_div;
			saved_valid	<= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				reg_op		<= op;
				saved_valid	<= 1'b1;
				if (reuse) begin
					done	<= 1'b1;
				end else begin
					state	<= s_calc;
					counter	<= count_bits'(1);
				end
			end else if (state == s_calc) begin
				if (counter == count_bits'(step_count - 1)) begin
					state	<= s_idle;
					done	<= 1'b1;
				end else begin
					counter	<= counter + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			prev_a	<= a;
			prev_b	<= b;
		end
		if (start && !reuse) begin
			reg_b	<= mag_b;
			// A zero divisor keeps the quotient positive so it reads all ones
			q_sgn	<= (a_neg ^ b_neg) && (b != '0);
			r_sgn	<= a_neg;
		end
		if ((start && !reuse) || state == s_calc) begin
			reg_res	<= {chain_res[xlen-step_bits-1:0], q};
			reg_rem	<= acc[step_bits];
		end
	end

	start_while_calc: assert property (@(posedge clk) disable iff (reset)
		start |-> state == s_idle);

endmodule

// ==== hdl/int_multiplier.sv ====
module int_multiplier (
	input	logic							clk,
	input	logic							reset,
	input	logic							start,

	input	muldiv_pkg::muldiv_op_t			op,

	input	logic	[muldiv_pkg::xlen-1:0]	a,
	input	logic	[muldiv_pkg::xlen-1:0]	b,

	output	logic							done,
	output	logic	[muldiv_pkg::xlen-1:0]	result
);

	import muldiv_pkg::*;

	typedef enum logic {s_idle, s_calc} state_t;

	state_t						state;
	logic	[count_bits-1:0]	counter;

	muldiv_op_t					reg_op;
	logic						reg_neg;
	logic	[2*xlen-1:0]		mcand;
	logic	[xlen-1:0]			mplier;
	logic	[2*xlen-1:0]		acc;

	logic						a_signed;
	logic						b_signed;
	logic						a_neg;
	logic						b_neg;
	logic	[xlen-1:0]			mag_a;
	logic	[xlen-1:0]			mag_b;

	logic	[2*xlen-1:0]		mcand_in;
	logic	[xlen-1:0]			mplier_in;
	logic	[2*xlen-1:0]		acc_in;
	logic	[2*xlen-1:0]		partial;
	logic	[2*xlen-1:0]		product;

	// MULH treats both operands as signed, MULHSU only a
	assign a_signed	= (op == op_mulh) || (op == op_mulhsu);
	assign b_signed	= (op == op_mulh);
	assign a_neg	= a_signed && a[xlen-1];
	assign b_neg	= b_signed && b[xlen-1];
	assign mag_a	= a_neg ? -a : a;
	assign mag_b	= b_neg ? -b : b;

	// The first step is taken at the start edge straight from the operands
	always_comb begin
		if (start) begin
			mcand_in	= {{xlen{1'b0}}, mag_a};
			mplier_in	= mag_b;
			acc_in		= '0;
		end else begin
			mcand_in	= mcand;
			mplier_in	= mplier;
			acc_in		= acc;
		end

		partial = '0;
		for (int i = 0; i < step_bits; i++) begin
			if (mplier_in[i])
				partial = partial + (mcand_in << i);
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state	<= s_idle;
			counter	<= '0;
			done	<= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				state	<= s_calc;
				counter	<= count_bits'(1);
			end else if (state == s_calc) begin
				if (counter == count_bits'(step_count - 1)) begin
					state	<= s_idle;
					done	<= 1'b1;
				end else begin
					counter	<= counter + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			reg_op	<= op;
			reg_neg	<= a_neg ^ b_neg;
		end
		if (start || state == s_calc) begin
			mcand	<= mcand_in << step_bits;
			mplier	<= mplier_in >> step_bits;
			acc		<= acc_in + partial;
		end
	end

	assign product	= reg_neg ? -acc : acc;
	assign result	= (reg_op == op_mul) ? product[xlen-1:0] : product[2*xlen-1:xlen];

	// Sequencer must wait for done before restarting
	start_while_calc: assert property (@(posedge clk) disable iff (reset)
		start |-> state == s_idle);

endmodule

// ==== hdl/muldiv_pkg.sv ====
package muldiv_pkg;

	// Operand and result width
	localparam int xlen = 32;

	// Quotient or multiplier bits resolved per cycle
	// xlen must be a multiple of step_bits, step_count relies on it
	localparam int step_bits = 8;

	localparam int step_count = xlen / step_bits;

	// Width of the iteration counters in both units
	localparam int count_bits = $clog2(step_count);

	// Values match funct3 of the M extension
	typedef enum logic [2:0] {
		op_mul    = 3'b000,
		op_mulh   = 3'b001,
		op_mulhsu = 3'b010,
		op_mulhu  = 3'b011,
		op_div    = 3'b100,
		op_divu   = 3'b101,
		op_rem    = 3'b110,
		op_remu   = 3'b111
	} muldiv_op_t;

	// Divide and remainder share funct3[2]
	function automatic logic is_div_op(input muldiv_op_t op);
		return op[2];
	endfunction

endpackage
